// ==== Bender.yml ====
package:
  name: battleship

sources:
  # Packages first, the interface next, then the modules and the top level
  - files:
      - source/bship_cfg_pkg.sv
      - source/bship_game_pkg.sv
      - source/bship_shot_if.sv
      - source/turn_fsm.sv
      - source/fleet_board.sv
      - source/pc_shot_gen.sv
      - source/battleship_top.sv

  # Testbench, top module battleship_tb
  - target: test
    files:
      - verif/battleship_tb.sv

// ==== all.f ====
source/bship_cfg_pkg.sv
source/bship_game_pkg.sv
source/bship_shot_if.sv
source/turn_fsm.sv
source/fleet_board.sv
source/pc_shot_gen.sv
source/battleship_top.sv
verif/battleship_tb.sv

// ==== source/battleship_top.sv ====
`default_nettype none

module battleship_top (
  input  logic                  clk,
  input  logic                  rst,          // Synchronous, active low
  input  logic                  start,        // Leave setup once both fleets are full
  input  logic                  place_player, // Place a ship on the player's board
  input  logic                  place_pc,     // Place a ship on the computer's board
  input  logic                  fire,         // Player shot strobe
  input  bship_cfg_pkg::coord_t place_x,      // Shared by both boards
  input  bship_cfg_pkg::coord_t place_y,
  input  bship_cfg_pkg::coord_t fire_x,
  input  bship_cfg_pkg::coord_t fire_y,
  output logic                  player_turn,
  output logic                  pc_turn,
  output logic                  is_victory,
  output logic                  is_defeat,
  output logic                  player_hit,   // Player struck a computer ship this cycle
  output logic                  pc_hit        // Computer struck a player ship this cycle
);

  import bship_cfg_pkg::*;

  logic      player_full;
  logic      pc_full;
  ship_cnt_t player_ships_next;
  ship_cnt_t pc_ships_next;

  // Player fires at the computer's board and the computer fires back at the player's
  bship_shot_if player_shot ();
  bship_shot_if pc_shot ();

  turn_fsm u_turn_fsm (
    .clk               (clk),
    .rst               (rst),
    .start             (start),
    .fire              (fire),
    .fire_x            (fire_x),
    .fire_y            (fire_y),
    .player_fleet_full (player_full),
    .pc_fleet_full     (pc_full),
    .player_ships_next (player_ships_next),
    .pc_ships_next     (pc_ships_next),
    .player_shot       (player_shot.shooter),
    .player_turn       (player_turn),
    .pc_turn           (pc_turn),
    .is_victory        (is_victory),
    .is_defeat         (is_defeat)
  );

  // Ships of the human player, the computer's scan lands here
  fleet_board player_board (
    .clk             (clk),
    .rst             (rst),
    .place           (place_player),
    .place_x         (place_x),
    .place_y         (place_y),
    .shot            (pc_shot.target),
    .full            (player_full),
    .ships_left_next (player_ships_next)
  );

  fleet_board pc_board (
    .clk             (clk),
    .rst             (rst),
    .place           (place_pc),
    .place_x         (place_x),
    .place_y         (place_y),
    .shot            (player_shot.target),
    .full            (pc_full),
    .ships_left_next (pc_ships_next)
  );

  pc_shot_gen u_pc_shot_gen (
    .clk     (clk),
    .rst     (rst),
    .pc_turn (pc_turn),
    .shot    (pc_shot.shooter)
  );

  assign player_hit = player_shot.hit;
  assign pc_hit     = pc_shot.hit;

endmodule

`default_nettype wire

// ==== source/bship_cfg_pkg.sv ====
`default_nettype none

package bship_cfg_pkg;

  // Both boards are square and share the same geometry
  localparam int unsigned BOARD_DIM = 8;

  // Bits needed to address one row or one column
  localparam int unsigned COORD_W = $clog2(BOARD_DIM);

  // Every cell of a board gets one bit in the ship map
  localparam int unsigned CELL_COUNT = BOARD_DIM * BOARD_DIM;

  // Ships per fleet, each ship covers a single cell
  localparam int unsigned SHIP_COUNT = 4;

  // Wide enough to hold the value SHIP_COUNT itself
  localparam int unsigned SHIP_CNT_W = $clog2(SHIP_COUNT + 1);

  // A single row or column number
  typedef logic [COORD_W-1:0] coord_t;

  // Linear cell number built as {y, x}
  typedef logic [2*COORD_W-1:0] cell_idx_t;

  // Number of ships placed or still afloat
  typedef logic [SHIP_CNT_W-1:0] ship_cnt_t;

  // An empty fleet, used for reset and for the end-of-game test
  localparam ship_cnt_t NO_SHIPS = '0;

  // Count at which a board stops taking placements
  localparam ship_cnt_t FLEET_FULL = ship_cnt_t'(SHIP_COUNT);

endpackage

`default_nettype wire

// ==== source/bship_game_pkg.sv ====
`default_nettype none

package bship_game_pkg;

  // Phases of one game, from setup to the end
  typedef enum logic [2:0] {
    START,       // Fleets are being placed, waiting for start
    PLAYER_TURN, // Player may fire one shot
    PC_TURN,     // Computer fires back during this single cycle
    VICTORY,     // Computer fleet is gone
    DEFEAT       // Player fleet is gone
  } game_state_t;

  // Step of the computer's scan across the linear cell index
  // Odd steps are coprime with the 64 cells, so every cell comes up once per lap
  localparam bship_cfg_pkg::cell_idx_t PC_STRIDE = 6'd5;

  // The computer starts its scan at the top left corner
  localparam bship_cfg_pkg::cell_idx_t PC_FIRST_CELL = '0;

endpackage

`default_nettype wire

// ==== source/bship_shot_if.sv ====
`default_nettype none

interface bship_shot_if;

  import bship_cfg_pkg::*;

  logic   fire; // One cycle strobe, a new shot in every cycle it is high
  coord_t x;    // Column of the target cell
  coord_t y;    // Row of the target cell

  // Combinational answer from the board in the same cycle as fire
  // High only while the cell still holds an unstruck ship
  logic hit;

  // Side that picks the cell and pulls the trigger
  modport shooter (
    output fire,
    output x,
    output y,
    input  hit
  );

  // Board that owns the ships and scores the shot
  modport target (
    input  fire,
    input  x,
    input  y,
    output hit
  );

endinterface

`default_nettype wire

// ==== source/fleet_board.sv ====
`default_nettype none

module fleet_board (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     place,           // Put a ship on place_x, place_y
  input  bship_cfg_pkg::coord_t    place_x,
  input  bship_cfg_pkg::coord_t    place_y,
  bship_shot_if.target             shot,            // Incoming fire from the other side
  output logic                     full,            // All ships of the fleet are on the board
  output bship_cfg_pkg::ship_cnt_t ships_left_next  // Afloat count once the current shot lands
);

  import bship_cfg_pkg::*;

  // One bit per cell, set while an unstruck ship sits there
  logic [CELL_COUNT-1:0] ship_map;

  ship_cnt_t placed_cnt; // Placements accepted since reset
  ship_cnt_t live_cnt;   // Ships still afloat

  cell_idx_t place_idx;
  cell_idx_t shot_idx;

  logic place_ok; // Placement that is actually taken
  logic shot_hit;

  // Row goes into the upper bits of the linear index
  assign place_idx = {place_y, place_x};
  assign shot_idx  = {shot.y, shot.x};

  assign full = (placed_cnt == FLEET_FULL);

  // Cells that already hold a ship and a full fleet both turn the strobe away
  assign place_ok = place && !full && !ship_map[place_idx];

  // A struck cell is cleared, so a second shot there scores nothing
  assign shot_hit = shot.fire && ship_map[shot_idx];
  assign shot.hit = shot_hit;

  // The turn controller needs the count before the edge that applies the hit
  assign ships_left_next = live_cnt - ship_cnt_t'(shot_hit);

  always_ff @(posedge clk) begin
    if (!rst) begin
      ship_map   <= '0;
      placed_cnt <= NO_SHIPS;
      live_cnt   <= NO_SHIPS;
    end else begin
      if (place_ok) begin
        ship_map[place_idx] <= 1'b1;
        placed_cnt          <= placed_cnt + ship_cnt_t'(1);
      end
      // Never collides with a placement, that needs an empty cell and a hit needs a ship
      if (shot_hit) begin
        ship_map[shot_idx] <= 1'b0; // The ship at this cell is sunk
      end
      live_cnt <= ships_left_next + ship_cnt_t'(place_ok); // New ship in, struck ship out
    end
  end

endmodule

`default_nettype wire

// ==== source/pc_shot_gen.sv ====
`default_nettype none

module pc_shot_gen (
  input  logic          clk,
  input  logic          rst,
  input  logic          pc_turn, // High for exactly one cycle per computer turn
  bship_shot_if.shooter shot     // Computer shots toward the player's board
);

  import bship_cfg_pkg::*;
  import bship_game_pkg::*;

  // Cell that the next computer shot goes to
  cell_idx_t scan_idx;

  // The whole computer turn is a single cycle, so it is also the trigger
  assign shot.fire = pc_turn;

  // Column sits in the low bits of the index and row in the high bits
  assign shot.x = scan_idx[COORD_W-1:0];
  assign shot.y = scan_idx[2*COORD_W-1:COORD_W];

  // The index only moves once the turn that used it is over
  // The add wraps at 64 on its own since the index is six bits wide
  always_ff @(posedge clk) begin
    if (!rst) begin
      scan_idx <= PC_FIRST_CELL;
    end else if (pc_turn) begin
      scan_idx <= scan_idx + PC_STRIDE; // Next cell in stride order
    end
  end

endmodule

`default_nettype wire

// ==== source/turn_fsm.sv ====
`default_nettype none

module turn_fsm (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,             // Begin the game once placement is done
  input  logic                     fire,              // Player trigger, counts only on the player turn
  input  bship_cfg_pkg::coord_t    fire_x,
  input  bship_cfg_pkg::coord_t    fire_y,
  input  logic                     player_fleet_full,
  input  logic                     pc_fleet_full,
  input  bship_cfg_pkg::ship_cnt_t player_ships_next, // Player ships left after this cycle's shot
  input  bship_cfg_pkg::ship_cnt_t pc_ships_next,     // Computer ships left after this cycle's shot
  bship_shot_if.shooter            player_shot,       // Player shots toward the computer's board
  output logic                     player_turn,
  output logic                     pc_turn,
  output logic                     is_victory,
  output logic                     is_defeat
);

  import bship_cfg_pkg::*;
  import bship_game_pkg::*;

  game_state_t state_reg;
  game_state_t state_next;

  logic fleets_ready; // Both boards hold a complete fleet
  logic player_fires; // Trigger seen while the player has the turn

  assign fleets_ready = player_fleet_full && pc_fleet_full;
  assign player_fires = fire && (state_reg == PLAYER_TURN);

  // The shot only reaches the computer's board during the player turn
  assign player_shot.fire = player_fires;
  assign player_shot.x    = fire_x;
  assign player_shot.y    = fire_y;

  always_ff @(posedge clk) begin
    if (!rst) begin
      state_reg <= START;
    end else begin
      state_reg <= state_next;
    end
  end

  always_comb begin
    state_next = state_reg; // Stay put unless an event below moves us
    case (state_reg)
      START: begin
        if (start && fleets_ready) state_next = PLAYER_TURN; // Early starts are dropped
      end
      PLAYER_TURN: begin
        if (player_fires) state_next = PC_TURN;
      end
      PC_TURN: begin
        // The computer board already took the player's shot one edge ago
        // The player board is scored in this very cycle, so look ahead on both
        if (pc_ships_next == NO_SHIPS) begin
          state_next = VICTORY; // A win is checked first
        end else if (player_ships_next == NO_SHIPS) begin
          state_next = DEFEAT;
        end else begin
          state_next = PLAYER_TURN;
        end
      end
      VICTORY, DEFEAT: begin
        state_next = state_reg; // Only reset leaves the end states
      end
      default: state_next = START;
    endcase
  end

  // One flag per visible state
  assign player_turn = (state_reg == PLAYER_TURN);
  assign pc_turn     = (state_reg == PC_TURN);
  assign is_victory  = (state_reg == VICTORY);
  assign is_defeat   = (state_reg == DEFEAT);

endmodule

`default_nettype wire

// ==== verif/battleship_tb.sv ====
`default_nettype none

module battleship_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import bship_cfg_pkg::*;
  import bship_game_pkg::*;

  // Visible game flags packed as {player_turn, pc_turn, is_victory, is_defeat}
  localparam logic [3:0] ST_START   = 4'b0000;
  localparam logic [3:0] ST_PLAYER  = 4'b1000;
  localparam logic [3:0] ST_PC      = 4'b0100;
  localparam logic [3:0] ST_VICTORY = 4'b0010;
  localparam logic [3:0] ST_DEFEAT  = 4'b0001;

  localparam int WAIT_LIMIT = 8; // Cycles any single wait may take

  typedef enum logic [2:0] {
    OP_IDLE,
    OP_RESET,
    OP_PLACE_PLAYER,
    OP_PLACE_PC,
    OP_START,
    OP_FIRE
  } op_t;

  // One table row: what to do and what the outputs must show
  typedef struct packed {
    op_t        op;
    coord_t     x;
    coord_t     y;
    logic       phit;  // player_hit in the strobe cycle
    logic       pchit; // pc_hit in the computer's turn
    logic [3:0] flags; // Game flags once the row has settled
  } row_t;

  logic   clk;
  logic   rst;
  logic   start;
  logic   place_player;
  logic   place_pc;
  logic   fire;
  coord_t place_x;
  coord_t place_y;
  coord_t fire_x;
  coord_t fire_y;
  logic   player_turn;
  logic   pc_turn;
  logic   is_victory;
  logic   is_defeat;
  logic   player_hit;
  logic   pc_hit;

  row_t   rows[$];
  integer seed;
  int     gap;

  // Reference model of both fleets and the computer's scan
  logic [CELL_COUNT-1:0] m_player_map;
  logic [CELL_COUNT-1:0] m_pc_map;
  int                    m_player_placed;
  int                    m_pc_placed;
  int                    m_player_live;
  int                    m_pc_live;
  int                    m_k; // Computer shots fired since reset
  logic [3:0]            m_flags;

  battleship_top UUT (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .place_player (place_player),
    .place_pc     (place_pc),
    .fire         (fire),
    .place_x      (place_x),
    .place_y      (place_y),
    .fire_x       (fire_x),
    .fire_y       (fire_y),
    .player_turn  (player_turn),
    .pc_turn      (pc_turn),
    .is_victory   (is_victory),
    .is_defeat    (is_defeat),
    .player_hit   (player_hit),
    .pc_hit       (pc_hit)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
    assert (act_v === exp_v) else begin
      $display("[ERROR] time %0t signal %s expected %0h actual %0h", $time, name, exp_v, act_v);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic add_row(input op_t op, input int x, input int y, input logic phit,
                         input logic pchit, input logic [3:0] flags);
    row_t r;
    r.op    = op;
    r.x     = coord_t'(x);
    r.y     = coord_t'(y);
    r.phit  = phit;
    r.pchit = pchit;
    r.flags = flags;
    rows.push_back(r);
  endtask

  task automatic do_reset();
    @(posedge clk);
    rst <= 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b1;
    m_player_map    = '0; // The model forgets both fleets along with the DUT
    m_pc_map        = '0;
    m_player_placed = 0;
    m_pc_placed     = 0;
    m_player_live   = 0;
    m_pc_live       = 0;
    m_k             = 0;
    m_flags         = ST_START;
  endtask

  task automatic model_step(input op_t op, input cell_idx_t idx);
    case (op)
      OP_PLACE_PLAYER: begin
        if (m_player_placed < SHIP_COUNT && !m_player_map[idx]) begin
          m_player_map[idx] = 1'b1;
          m_player_placed++;
          m_player_live++;
        end
      end
      OP_PLACE_PC: begin
        if (m_pc_placed < SHIP_COUNT && !m_pc_map[idx]) begin
          m_pc_map[idx] = 1'b1;
          m_pc_placed++;
          m_pc_live++;
        end
      end
      OP_START: begin
        if (m_flags == ST_START && m_player_placed == SHIP_COUNT && m_pc_placed == SHIP_COUNT)
          m_flags = ST_PLAYER;
      end
      OP_FIRE: begin
        if (m_flags == ST_PLAYER) begin
          if (m_pc_map[idx]) begin
            m_pc_map[idx] = 1'b0; // Struck ships never score twice
            m_pc_live--;
          end
          m_flags = ST_PC;
        end
      end
      default: ;
    endcase
  endtask

  task automatic model_pc_shot(input cell_idx_t target);
    if (m_player_map[target]) begin
      m_player_map[target] = 1'b0;
      m_player_live--;
    end
    m_k++;
    if (m_pc_live == 0) m_flags = ST_VICTORY; // Winning beats losing in the same turn
    else if (m_player_live == 0) m_flags = ST_DEFEAT;
    else m_flags = ST_PLAYER;
  endtask

  task automatic apply_row(input row_t r);
    logic      accepted;
    logic      m_phit;
    logic      m_pchit;
    cell_idx_t idx;
    cell_idx_t target;
    int        cyc;
    idx      = {r.y, r.x};
    accepted = (r.op == OP_FIRE) && (m_flags == ST_PLAYER);
    m_phit   = accepted && m_pc_map[idx];
    if (r.op == OP_RESET) begin
      do_reset();
    end else begin
      @(posedge clk);
      place_x <= r.x; // Both coordinate pairs follow the row
      place_y <= r.y;
      fire_x  <= r.x;
      fire_y  <= r.y;
      case (r.op)
        OP_PLACE_PLAYER: place_player <= 1'b1;
        OP_PLACE_PC:     place_pc <= 1'b1;
        OP_START:        start <= 1'b1;
        OP_FIRE:         fire <= 1'b1;
        default: ;
      endcase
      @(negedge clk);
      check_val("player_hit", r.phit, player_hit); // Combinational in the strobe cycle
      check_val("player_hit model", m_phit, player_hit);
      @(posedge clk);
      place_player <= 1'b0;
      place_pc     <= 1'b0;
      start        <= 1'b0;
      fire         <= 1'b0;
      model_step(r.op, idx);
    end
    if (accepted) begin
      // Stride rule: the k-th computer shot goes to cell 5*k mod 64
      target  = cell_idx_t'((m_k * int'(PC_STRIDE)) % CELL_COUNT);
      m_pchit = m_player_map[target];
      cyc = 0;
      @(negedge clk);
      while (!pc_turn) begin
        if (cyc == WAIT_LIMIT) fail_run("The computer turn never came after an accepted shot");
        @(negedge clk);
        cyc++;
      end
      check_val("pc_hit", r.pchit, pc_hit);
      check_val("pc_hit model", m_pchit, pc_hit);
      model_pc_shot(target);
      cyc = 1;
      @(negedge clk);
      while (pc_turn) begin
        if (cyc == WAIT_LIMIT) fail_run("The computer turn did not end");
        @(negedge clk);
        cyc++;
      end
      check_val("pc_turn cycles", 1, cyc);
    end else begin
      @(negedge clk);
    end
    check_val("state flags", r.flags, {player_turn, pc_turn, is_victory, is_defeat});
    check_val("state flags model", m_flags, {player_turn, pc_turn, is_victory, is_defeat});
    check_val("player_hit idle", 1'b0, player_hit);
    check_val("pc_hit idle", 1'b0, pc_hit);
  endtask

  task automatic build_table();
    // First game, the player sinks the computer fleet
    add_row(OP_RESET, 0, 0, 0, 0, ST_START);
    add_row(OP_START, 0, 0, 0, 0, ST_START); // Fleets still empty
    add_row(OP_PLACE_PC, 1, 0, 0, 0, ST_START);
    add_row(OP_PLACE_PC, 2, 3, 0, 0, ST_START);
    add_row(OP_PLACE_PC, 4, 4, 0, 0, ST_START);
    add_row(OP_PLACE_PC, 6, 5, 0, 0, ST_START);
    add_row(OP_PLACE_PLAYER, 7, 7, 0, 0, ST_START);
    add_row(OP_PLACE_PLAYER, 7, 7, 0, 0, ST_START); // Same cell twice
    add_row(OP_PLACE_PLAYER, 6, 7, 0, 0, ST_START);
    add_row(OP_PLACE_PLAYER, 5, 7, 0, 0, ST_START);
    add_row(OP_START, 0, 0, 0, 0, ST_START); // Only three player ships so far
    add_row(OP_PLACE_PLAYER, 4, 7, 0, 0, ST_START);
    add_row(OP_PLACE_PC, 7, 0, 0, 0, ST_START); // Fifth ship is turned away
    add_row(OP_FIRE, 1, 0, 0, 0, ST_START);
    add_row(OP_START, 0, 0, 0, 0, ST_PLAYER);
    add_row(OP_FIRE, 1, 0, 1, 0, ST_PLAYER);
    add_row(OP_FIRE, 1, 0, 0, 0, ST_PLAYER); // Already struck
    add_row(OP_FIRE, 7, 0, 0, 0, ST_PLAYER);
    add_row(OP_FIRE, 2, 3, 1, 0, ST_PLAYER);
    add_row(OP_FIRE, 4, 4, 1, 0, ST_PLAYER);
    add_row(OP_FIRE, 6, 5, 1, 0, ST_VICTORY);
    add_row(OP_FIRE, 6, 5, 0, 0, ST_VICTORY);
    add_row(OP_START, 0, 0, 0, 0, ST_VICTORY);
    add_row(OP_IDLE, 0, 0, 0, 0, ST_VICTORY);
    // Second game, player ships sit on cells 0, 5, 10 and 15 of the scan
    add_row(OP_RESET, 0, 0, 0, 0, ST_START);
    add_row(OP_PLACE_PLAYER, 0, 0, 0, 0, ST_START);
    add_row(OP_PLACE_PLAYER, 5, 0, 0, 0, ST_START);
    add_row(OP_PLACE_PLAYER, 2, 1, 0, 0, ST_START);
    add_row(OP_PLACE_PLAYER, 7, 1, 0, 0, ST_START);
    add_row(OP_PLACE_PC, 7, 7, 0, 0, ST_START);
    add_row(OP_PLACE_PC, 6, 7, 0, 0, ST_START);
    add_row(OP_PLACE_PC, 5, 7, 0, 0, ST_START);
    add_row(OP_PLACE_PC, 4, 7, 0, 0, ST_START);
    add_row(OP_START, 0, 0, 0, 0, ST_PLAYER);
    add_row(OP_FIRE, 0, 0, 0, 1, ST_PLAYER);
    add_row(OP_FIRE, 1, 0, 0, 1, ST_PLAYER);
    add_row(OP_FIRE, 2, 0, 0, 1, ST_PLAYER);
    add_row(OP_FIRE, 3, 0, 0, 1, ST_DEFEAT);
    add_row(OP_FIRE, 7, 7, 0, 0, ST_DEFEAT);
    add_row(OP_START, 0, 0, 0, 0, ST_DEFEAT);
  endtask

  initial begin
    seed         = 44;
    rst          <= 1'b0;
    start        <= 1'b0;
    place_player <= 1'b0;
    place_pc     <= 1'b0;
    fire         <= 1'b0;
    place_x      <= '0;
    place_y      <= '0;
    fire_x       <= '0;
    fire_y       <= '0;
    build_table();
    foreach (rows[i]) begin
      gap = $unsigned($random(seed)) % 4; // Idle cycles never move the game
      repeat (gap) @(posedge clk);
      apply_row(rows[i]);
    end
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire
